//--- hdl/isaPkg.sv
package isaPkg;

    typedef logic [15:0] wordT;
    typedef logic [1:0]  regIdxT;
    typedef logic [7:0]  immFieldT;

    typedef enum logic [3:0] {
        BNE   = 4'd0,
        BEQ   = 4'd1,
        BGZ   = 4'd2,
        BLZ   = 4'd3,
        ADI   = 4'd4,
        ORI   = 4'd5,
        LHI   = 4'd6,
        LWD   = 4'd7,
        SWD   = 4'd8,
        JMP   = 4'd9,
        JAL   = 4'd10,
        RTYPE = 4'd15
    } opcodeT;

    // low three bits of the ALU functions match aluOpT
    typedef enum logic [5:0] {
        ADD = 6'd0,
        SUB = 6'd1,
        AND = 6'd2,
        ORR = 6'd3,
        NOT = 6'd4,
        TCP = 6'd5,
        SHL = 6'd6,
        SHR = 6'd7,
        JPR = 6'd25,
        JRL = 6'd26,
        WWD = 6'd28,
        HLT = 6'd29
    } funcT;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR
    } aluOpT;

    localparam regIdxT LINK_REG = 2'd2;
    localparam int NUM_REGS = 4;

    localparam int OPCODE_MSB = 15;
    localparam int OPCODE_LSB = 12;
    localparam int RS_MSB = 11;
    localparam int RS_LSB = 10;
    localparam int RT_MSB = 9;
    localparam int RT_LSB = 8;
    localparam int RD_MSB = 7;
    localparam int RD_LSB = 6;
    localparam int FUNC_MSB = 5;
    localparam int IMM_MSB = 7;
    localparam int JUMP_MSB = 11;

    // R-type with an unused func, decoded as a bubble
    localparam wordT BUBBLE_INSTR = 16'hf03f;

endpackage

//--- hdl/pipePkg.sv
package pipePkg;

    typedef struct packed {
        isaPkg::wordT pcPlus1;
        isaPkg::wordT instr;
    } ifIdT;

    typedef struct packed {
        logic           valid;
        logic           regWrite;
        logic           memRead;
        logic           memWrite;
        logic           wwd;
        logic           halt;
        logic           isLink;     // result is pcPlus1
        logic           isLhi;      // result is imm in upper byte
        isaPkg::aluOpT  aluOp;
        logic           aluSrcImm;
        isaPkg::wordT   opA;
        isaPkg::wordT   opB;
        isaPkg::wordT   imm;
        isaPkg::wordT   pcPlus1;
        isaPkg::regIdxT rs;
        isaPkg::regIdxT rt;
        isaPkg::regIdxT dest;
    } idExT;

    typedef struct packed {
        logic           valid;
        logic           regWrite;
        logic           memRead;
        logic           memWrite;
        logic           wwd;
        logic           halt;
        isaPkg::wordT   result;
        isaPkg::wordT   storeData;
        isaPkg::wordT   wwdValue;
        isaPkg::regIdxT dest;
    } exMemT;

    typedef struct packed {
        logic           valid;
        logic           regWrite;
        logic           load;
        logic           wwd;
        logic           halt;
        isaPkg::wordT   loadData;
        isaPkg::wordT   result;
        isaPkg::wordT   wwdValue;
        isaPkg::regIdxT dest;
    } memWbT;

    typedef struct packed {
        logic           regWrite;
        isaPkg::regIdxT dest;
        isaPkg::wordT   data;
    } wbT;

    typedef enum logic [1:0] {
        NONE,
        FROM_MEM,
        FROM_WB
    } fwdSelT;

endpackage

//--- hdl/fetchStage.sv
`timescale 1ns/100ps

module fetchStage (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  logic           redirect,
    input  isaPkg::wordT   redirectTarget,
    input  logic           halt,
    output logic           instrRead,
    output isaPkg::wordT   instrAddr,
    input  isaPkg::wordT   instrData,
    output pipePkg::ifIdT  ifId
);

    isaPkg::wordT pc;
    isaPkg::wordT pcPlus1;
    isaPkg::wordT nextPc;

    assign pcPlus1 = pc + 16'd1;
    assign nextPc = redirect ? redirectTarget : pcPlus1;

    assign instrRead = ~halt;
    assign instrAddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect || (!stall && !halt)) begin
            pc <= nextPc;
        end
    end

    // squashed slot turns into a bubble
    always_ff @(posedge clk) begin
        if (rst || redirect || halt) begin
            ifId.pcPlus1 <= '0;
            ifId.instr <= isaPkg::BUBBLE_INSTR;
        end else if (!stall) begin
            ifId.pcPlus1 <= pcPlus1;
            ifId.instr <= instrData;
        end
    end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic           clk,
    input  logic           rst,
    input  isaPkg::regIdxT rs,
    input  isaPkg::regIdxT rt,
    output isaPkg::wordT   rdataA,
    output isaPkg::wordT   rdataB,
    input  pipePkg::wbT    wb
);

    isaPkg::wordT regs [isaPkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < isaPkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.regWrite) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // writeback in the same cycle wins
    assign rdataA = (wb.regWrite && wb.dest == rs) ? wb.data : regs[rs];
    assign rdataB = (wb.regWrite && wb.dest == rt) ? wb.data : regs[rt];

endmodule

//--- hdl/decodeStage.sv
`timescale 1ns/100ps

module decodeStage (
    input  logic           clk,
    input  logic           rst,
    input  pipePkg::ifIdT  ifId,
    output isaPkg::regIdxT rs,
    output isaPkg::regIdxT rt,
    input  isaPkg::wordT   rdataA,
    input  isaPkg::wordT   rdataB,
    input  pipePkg::exMemT exFwd,
    output pipePkg::idExT  idEx,
    output logic           stall,
    output logic           redirect,
    output isaPkg::wordT   redirectTarget,
    output logic           halt
);

    isaPkg::wordT     instr;
    isaPkg::opcodeT   opcode;
    isaPkg::funcT     func;
    isaPkg::immFieldT imm8;
    isaPkg::wordT     immExt;
    isaPkg::wordT     opA;
    isaPkg::wordT     opB;
    pipePkg::idExT    ctrl;
    logic zeroExt, usesRs, usesRt;
    logic isBranch, jumpAbs, jumpReg, taken;
    logic rsBusy, rtBusy, loadUse, branchHaz;
    logic haltSeen;

    assign instr = ifId.instr;
    assign opcode = isaPkg::opcodeT'(instr[isaPkg::OPCODE_MSB:isaPkg::OPCODE_LSB]);
    assign func = isaPkg::funcT'(instr[isaPkg::FUNC_MSB:0]);
    assign rs = instr[isaPkg::RS_MSB:isaPkg::RS_LSB];
    assign rt = instr[isaPkg::RT_MSB:isaPkg::RT_LSB];
    assign imm8 = instr[isaPkg::IMM_MSB:0];
    assign immExt = zeroExt ? {8'h00, imm8} : {{8{imm8[7]}}, imm8};

    // ALU results still in EX/MEM come straight across
    assign opA = (exFwd.valid && exFwd.regWrite && exFwd.dest == rs) ? exFwd.result : rdataA;
    assign opB = (exFwd.valid && exFwd.regWrite && exFwd.dest == rt) ? exFwd.result : rdataB;

    always_comb begin
        ctrl = '0;
        ctrl.valid = 1'b1;
        ctrl.aluOp = isaPkg::ALU_ADD;
        ctrl.dest = rt;
        {zeroExt, usesRs, usesRt, isBranch, jumpAbs, jumpReg} = '0;
        case (opcode)
            isaPkg::BNE, isaPkg::BEQ: {isBranch, usesRs, usesRt} = 3'b111;
            isaPkg::BGZ, isaPkg::BLZ: {isBranch, usesRs} = 2'b11;
            isaPkg::ADI: {ctrl.regWrite, ctrl.aluSrcImm, usesRs} = 3'b111;
            isaPkg::ORI: begin
                {ctrl.regWrite, ctrl.aluSrcImm, usesRs, zeroExt} = 4'b1111;
                ctrl.aluOp = isaPkg::ALU_OR;
            end
            isaPkg::LHI: {ctrl.regWrite, ctrl.isLhi} = 2'b11;
            isaPkg::LWD: {ctrl.regWrite, ctrl.memRead, ctrl.aluSrcImm, usesRs} = 4'b1111;
            isaPkg::SWD: {ctrl.memWrite, ctrl.aluSrcImm, usesRs, usesRt} = 4'b1111;
            isaPkg::JMP: jumpAbs = 1'b1;
            isaPkg::JAL: begin
                {jumpAbs, ctrl.regWrite, ctrl.isLink} = 3'b111;
                ctrl.dest = isaPkg::LINK_REG;
            end
            isaPkg::RTYPE: begin
                ctrl.dest = instr[isaPkg::RD_MSB:isaPkg::RD_LSB];
                ctrl.aluOp = isaPkg::aluOpT'(func[2:0]);
                case (func)
                    isaPkg::ADD, isaPkg::SUB, isaPkg::AND, isaPkg::ORR:
                        {ctrl.regWrite, usesRs, usesRt} = 3'b111;
                    isaPkg::NOT, isaPkg::TCP, isaPkg::SHL, isaPkg::SHR:
                        {ctrl.regWrite, usesRs} = 2'b11;
                    isaPkg::JPR: {jumpReg, usesRs} = 2'b11;
                    isaPkg::JRL: begin
                        {jumpReg, usesRs, ctrl.regWrite, ctrl.isLink} = 4'b1111;
                        ctrl.dest = isaPkg::LINK_REG;
                    end
                    isaPkg::WWD: {ctrl.wwd, usesRs} = 2'b11;
                    isaPkg::HLT: ctrl.halt = 1'b1;
                    default: ctrl.valid = 1'b0;   // also the flush bubble
                endcase
            end
            default: ctrl.valid = 1'b0;
        endcase
        ctrl.opA = opA;
        ctrl.opB = opB;
        ctrl.imm = immExt;
        ctrl.pcPlus1 = ifId.pcPlus1;
        ctrl.rs = rs;
        ctrl.rt = rt;
    end

    // register not yet readable for a compare in decode
    assign rsBusy = (idEx.valid && idEx.regWrite && idEx.dest == rs) ||
                    (exFwd.valid && exFwd.memRead && exFwd.dest == rs);
    assign rtBusy = (idEx.valid && idEx.regWrite && idEx.dest == rt) ||
                    (exFwd.valid && exFwd.memRead && exFwd.dest == rt);

    assign loadUse = idEx.valid && idEx.memRead &&
                     ((usesRs && idEx.dest == rs) || (usesRt && idEx.dest == rt));
    assign branchHaz = (isBranch || jumpReg) && ((usesRs && rsBusy) || (usesRt && rtBusy));
    assign stall = ctrl.valid && (loadUse || branchHaz);

    always_comb begin
        case (opcode)
            isaPkg::BNE: taken = opA != opB;
            isaPkg::BEQ: taken = opA == opB;
            isaPkg::BGZ: taken = $signed(opA) > 0;
            isaPkg::BLZ: taken = $signed(opA) < 0;
            default:     taken = 1'b0;
        endcase
    end

    assign redirect = ctrl.valid && !stall && ((isBranch && taken) || jumpAbs || jumpReg);

    always_comb begin
        if (jumpReg) begin
            redirectTarget = opA;
        end else if (jumpAbs) begin
            redirectTarget = {ifId.pcPlus1[15:isaPkg::JUMP_MSB+1], instr[isaPkg::JUMP_MSB:0]};
        end else begin
            redirectTarget = ifId.pcPlus1 + immExt;
        end
    end

    // fetch stays frozen once HLT has been seen
    assign halt = haltSeen || (ctrl.valid && ctrl.halt);

    always_ff @(posedge clk) begin
        if (rst) begin
            haltSeen <= 1'b0;
        end else if (ctrl.valid && ctrl.halt) begin
            haltSeen <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || stall) begin
            idEx <= '0;   // bubble
        end else begin
            idEx <= ctrl;
        end
    end

endmodule

//--- hdl/executeStage.sv
`timescale 1ns/100ps

module executeStage (
    input  logic           clk,
    input  logic           rst,
    input  pipePkg::idExT  idEx,
    input  pipePkg::wbT    wb,
    output pipePkg::exMemT exMem
);

    pipePkg::fwdSelT selA;
    pipePkg::fwdSelT selB;
    isaPkg::wordT    srcA;
    isaPkg::wordT    srcB;
    isaPkg::wordT    aluB;
    isaPkg::wordT    aluOut;
    isaPkg::wordT    result;

    // nearest producer first
    function automatic pipePkg::fwdSelT pickSource(isaPkg::regIdxT src, pipePkg::exMemT mem,
                                                   pipePkg::wbT w);
        if (mem.valid && mem.regWrite && mem.dest == src) begin
            return pipePkg::FROM_MEM;
        end else if (w.regWrite && w.dest == src) begin
            return pipePkg::FROM_WB;
        end
        return pipePkg::NONE;
    endfunction

    assign selA = pickSource(idEx.rs, exMem, wb);
    assign selB = pickSource(idEx.rt, exMem, wb);

    always_comb begin
        case (selA)
            pipePkg::FROM_MEM: srcA = exMem.result;
            pipePkg::FROM_WB:  srcA = wb.data;
            default:           srcA = idEx.opA;
        endcase
        case (selB)
            pipePkg::FROM_MEM: srcB = exMem.result;
            pipePkg::FROM_WB:  srcB = wb.data;
            default:           srcB = idEx.opB;
        endcase
    end

    assign aluB = idEx.aluSrcImm ? idEx.imm : srcB;

    always_comb begin
        case (idEx.aluOp)
            isaPkg::ALU_ADD: aluOut = srcA + aluB;
            isaPkg::ALU_SUB: aluOut = srcA - aluB;
            isaPkg::ALU_AND: aluOut = srcA & aluB;
            isaPkg::ALU_OR:  aluOut = srcA | aluB;
            isaPkg::ALU_NOT: aluOut = ~srcA;
            isaPkg::ALU_TCP: aluOut = ~srcA + 16'd1;
            isaPkg::ALU_SHL: aluOut = {srcA[14:0], 1'b0};
            default:         aluOut = {srcA[15], srcA[15:1]};   // arithmetic
        endcase
    end

    always_comb begin
        if (idEx.isLink) begin
            result = idEx.pcPlus1;
        end else if (idEx.isLhi) begin
            result = {idEx.imm[7:0], 8'h00};
        end else begin
            result = aluOut;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exMem <= '0;
        end else begin
            exMem.valid <= idEx.valid;
            exMem.regWrite <= idEx.regWrite;
            exMem.memRead <= idEx.memRead;
            exMem.memWrite <= idEx.memWrite;
            exMem.wwd <= idEx.wwd;
            exMem.halt <= idEx.halt;
            exMem.result <= result;
            exMem.storeData <= srcB;
            exMem.wwdValue <= srcA;
            exMem.dest <= idEx.dest;
        end
    end

endmodule

//--- hdl/memWriteback.sv
`timescale 1ns/100ps

module memWriteback (
    input  logic           clk,
    input  logic           rst,
    input  pipePkg::exMemT exMem,
    output logic           dataRead,
    output logic           dataWrite,
    output isaPkg::wordT   dataAddr,
    output isaPkg::wordT   dataWdata,
    input  isaPkg::wordT   dataRdata,
    output pipePkg::wbT    wb,
    output isaPkg::wordT   outputPort,
    output logic           outputValid,
    output logic           isHalted,
    output isaPkg::wordT   numInst
);

    pipePkg::memWbT memWb;
    isaPkg::wordT   instCount;
    logic           haltLatch;
    logic           haltNow;

    assign dataRead = exMem.valid & exMem.memRead;
    assign dataWrite = exMem.valid & exMem.memWrite;
    assign dataAddr = exMem.result;
    assign dataWdata = exMem.storeData;

    always_ff @(posedge clk) begin
        if (rst) begin
            memWb <= '0;
        end else begin
            memWb.valid <= exMem.valid;
            memWb.regWrite <= exMem.regWrite;
            memWb.load <= exMem.memRead;
            memWb.wwd <= exMem.wwd;
            memWb.halt <= exMem.halt;
            memWb.loadData <= dataRdata;   // combinational read
            memWb.result <= exMem.result;
            memWb.wwdValue <= exMem.wwdValue;
            memWb.dest <= exMem.dest;
        end
    end

    assign wb.regWrite = memWb.valid & memWb.regWrite;
    assign wb.dest = memWb.dest;
    assign wb.data = memWb.load ? memWb.loadData : memWb.result;

    assign outputPort = memWb.wwdValue;
    assign outputValid = memWb.valid & memWb.wwd;

    assign haltNow = memWb.valid & memWb.halt;
    assign isHalted = haltLatch | haltNow;

    always_ff @(posedge clk) begin
        if (rst) begin
            haltLatch <= 1'b0;
            instCount <= '0;
        end else begin
            if (haltNow) begin
                haltLatch <= 1'b1;
            end
            if (memWb.valid) begin
                instCount <= instCount + 16'd1;
            end
        end
    end

    // includes the instruction now in writeback
    assign numInst = instCount + isaPkg::wordT'(memWb.valid);

endmodule

//--- hdl/pipelineCpu.sv
`timescale 1ns/100ps

module pipelineCpu (
    input  logic         clk,
    input  logic         rst,
    output logic         instrRead,
    output isaPkg::wordT instrAddr,
    input  isaPkg::wordT instrData,
    output logic         dataRead,
    output logic         dataWrite,
    output isaPkg::wordT dataAddr,
    output isaPkg::wordT dataWdata,
    input  isaPkg::wordT dataRdata,
    output isaPkg::wordT outputPort,
    output logic         outputValid,
    output logic         isHalted,
    output isaPkg::wordT numInst
);

    pipePkg::ifIdT  ifId;
    pipePkg::idExT  idEx;
    pipePkg::exMemT exMem;
    pipePkg::wbT    wb;
    isaPkg::regIdxT rs;
    isaPkg::regIdxT rt;
    isaPkg::wordT   rdataA;
    isaPkg::wordT   rdataB;
    isaPkg::wordT   redirectTarget;
    logic           stall;
    logic           redirect;
    logic           halt;

    fetchStage u_fetchStage (
        .clk, .rst, .stall, .redirect, .redirectTarget, .halt,
        .instrRead, .instrAddr, .instrData, .ifId
    );

    regFile u_regFile (
        .clk, .rst, .rs, .rt, .rdataA, .rdataB, .wb
    );

    decodeStage u_decodeStage (
        .clk, .rst, .ifId, .rs, .rt, .rdataA, .rdataB,
        .exFwd(exMem), .idEx, .stall, .redirect, .redirectTarget, .halt
    );

    executeStage u_executeStage (
        .clk, .rst, .idEx, .wb, .exMem
    );

    memWriteback u_memWriteback (
        .clk, .rst, .exMem, .dataRead, .dataWrite, .dataAddr, .dataWdata, .dataRdata,
        .wb, .outputPort, .outputValid, .isHalted, .numInst
    );

endmodule

//--- test/tbPipelineCpu.sv
`timescale 1ns/100ps

module tbPipelineCpu;

    localparam int MEM_WORDS = 64;
    localparam int RESET_CYCLES = 5;
    localparam int CYCLE_LIMIT = 200;   // the longest program needs about 60 per test
    localparam int TAIL_CYCLES = 6;
    localparam int STEP_LIMIT = 500;
    localparam int RANDOM_LENGTH = 40;
    localparam logic [31:0] LFSR_SEED = 32'h9086c5be;
    localparam logic [31:0] LFSR_TAPS = 32'ha3000000;

    localparam isaPkg::regIdxT R0 = 2'd0;
    localparam isaPkg::regIdxT R1 = 2'd1;
    localparam isaPkg::regIdxT R2 = 2'd2;
    localparam isaPkg::regIdxT R3 = 2'd3;

    logic         clk = 1'b0;
    logic         rst = 1'b1;
    logic         instrRead;
    isaPkg::wordT instrAddr;
    isaPkg::wordT instrData;
    logic         dataRead;
    logic         dataWrite;
    isaPkg::wordT dataAddr;
    isaPkg::wordT dataWdata;
    isaPkg::wordT dataRdata;
    isaPkg::wordT outputPort;
    logic         outputValid;
    logic         isHalted;
    isaPkg::wordT numInst;

    isaPkg::wordT instrMem [MEM_WORDS] = '{default: '0};
    isaPkg::wordT dataMem [MEM_WORDS] = '{default: '0};
    isaPkg::wordT refMem [MEM_WORDS];
    isaPkg::wordT refReg [isaPkg::NUM_REGS];
    isaPkg::wordT progWords [$];
    isaPkg::wordT expOut [$];
    int           expCount;
    logic [31:0]  lfsrState = LFSR_SEED;

    always #50 clk = ~clk;

    pipelineCpu u_pipelineCpu (
        .clk, .rst, .instrRead, .instrAddr, .instrData,
        .dataRead, .dataWrite, .dataAddr, .dataWdata, .dataRdata,
        .outputPort, .outputValid, .isHalted, .numInst
    );

    // both memories answer in the same cycle
    assign instrData = instrMem[instrAddr[5:0]];
    assign dataRdata = dataRead ? dataMem[dataAddr[5:0]] : '0;   // only on a read strobe

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                dataMem[i] <= dataFill(6'(i));   // refilled on every reset
            end
        end else if (dataWrite) begin
            dataMem[dataAddr[5:0]] <= dataWdata;
        end
    end

    function automatic isaPkg::wordT dataFill(logic [5:0] addr);
        return {addr, 4'hc, ~addr};
    endfunction

    // HLT with the address in its register fields
    function automatic isaPkg::wordT instrFill(logic [5:0] addr);
        return {isaPkg::RTYPE, addr, isaPkg::HLT};
    endfunction

    function automatic isaPkg::wordT rType(isaPkg::funcT fn, isaPkg::regIdxT rs,
                                           isaPkg::regIdxT rt, isaPkg::regIdxT rd);
        return {isaPkg::RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic isaPkg::wordT iType(isaPkg::opcodeT op, isaPkg::regIdxT rs,
                                           isaPkg::regIdxT rt, logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic isaPkg::wordT jType(isaPkg::opcodeT op, logic [11:0] target);
        return {op, target};
    endfunction

    function automatic isaPkg::wordT writeOut(isaPkg::regIdxT rs);
        return rType(isaPkg::WWD, rs, R0, R0);
    endfunction

    function automatic void emit(isaPkg::wordT word);
        progWords.push_back(word);
    endfunction

    function automatic logic lfsrBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ LFSR_TAPS;
        end
        return outBit;
    endfunction

    function automatic logic [15:0] randomBits(int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], lfsrBit()};
        end
        return value;
    endfunction

    task automatic abortRun(string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "run aborted");
    endtask

    task automatic checkValue(string name, isaPkg::wordT actual, isaPkg::wordT expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // ISA interpreter that fills expOut, expCount and refMem
    task automatic interpret();
        isaPkg::wordT   pc;
        isaPkg::wordT   ins;
        isaPkg::wordT   a;
        isaPkg::wordT   b;
        isaPkg::wordT   immS;
        isaPkg::wordT   addr;
        isaPkg::opcodeT op;
        isaPkg::funcT   fn;
        isaPkg::regIdxT rs;
        isaPkg::regIdxT rt;
        isaPkg::regIdxT rd;
        logic           done;
        int             steps;
        pc = '0;
        done = 1'b0;
        steps = 0;
        expCount = 0;
        expOut.delete();
        for (int i = 0; i < isaPkg::NUM_REGS; i++) begin
            refReg[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            refMem[i] = dataFill(6'(i));
        end
        while (!done) begin
            if (steps == STEP_LIMIT) begin
                abortRun("reference model never reached HLT");
            end
            ins = instrMem[pc[5:0]];
            op = isaPkg::opcodeT'(ins[15:12]);
            fn = isaPkg::funcT'(ins[5:0]);
            rs = ins[11:10];
            rt = ins[9:8];
            rd = ins[7:6];
            a = refReg[rs];
            b = refReg[rt];
            immS = {{8{ins[7]}}, ins[7:0]};
            addr = a + immS;
            pc = pc + 16'd1;   // branches are relative to the next word
            steps++;
            expCount++;
            case (op)
                isaPkg::BNE: if (a != b) pc = pc + immS;
                isaPkg::BEQ: if (a == b) pc = pc + immS;
                isaPkg::BGZ: if ($signed(a) > 16'sd0) pc = pc + immS;
                isaPkg::BLZ: if ($signed(a) < 16'sd0) pc = pc + immS;
                isaPkg::ADI: refReg[rt] = a + immS;
                isaPkg::ORI: refReg[rt] = a | {8'h00, ins[7:0]};
                isaPkg::LHI: refReg[rt] = {ins[7:0], 8'h00};
                isaPkg::LWD: refReg[rt] = refMem[addr[5:0]];
                isaPkg::SWD: refMem[addr[5:0]] = b;
                isaPkg::JMP: pc = {pc[15:12], ins[11:0]};
                isaPkg::JAL: begin
                    refReg[isaPkg::LINK_REG] = pc;
                    pc = {pc[15:12], ins[11:0]};
                end
                isaPkg::RTYPE: begin
                    case (fn)
                        isaPkg::ADD: refReg[rd] = a + b;
                        isaPkg::SUB: refReg[rd] = a - b;
                        isaPkg::AND: refReg[rd] = a & b;
                        isaPkg::ORR: refReg[rd] = a | b;
                        isaPkg::NOT: refReg[rd] = ~a;
                        isaPkg::TCP: refReg[rd] = 16'd0 - a;
                        isaPkg::SHL: refReg[rd] = a << 1;
                        isaPkg::SHR: refReg[rd] = isaPkg::wordT'($signed(a) >>> 1);
                        isaPkg::JPR: pc = a;
                        isaPkg::JRL: begin
                            refReg[isaPkg::LINK_REG] = pc;
                            pc = a;
                        end
                        isaPkg::WWD: expOut.push_back(a);
                        isaPkg::HLT: done = 1'b1;
                        default: abortRun("reference model met an unknown function");
                    endcase
                end
                default: abortRun("reference model met an unknown opcode");
            endcase
        end
    endtask

    task automatic resetDut();
        @(posedge clk);
        rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("instrAddr", instrAddr, 16'h0000);
        checkValue("instrRead", {15'd0, instrRead}, 16'd1);
        checkValue("dataRead", {15'd0, dataRead}, 16'd0);
        checkValue("dataWrite", {15'd0, dataWrite}, 16'd0);
        checkValue("outputValid", {15'd0, outputValid}, 16'd0);
        checkValue("isHalted", {15'd0, isHalted}, 16'd0);
        checkValue("numInst", numInst, 16'd0);
    endtask

    task automatic runProgram(string name);
        isaPkg::wordT got [$];
        int           cycles;
        for (int i = 0; i < MEM_WORDS; i++) begin
            instrMem[i] = instrFill(6'(i));
        end
        foreach (progWords[i]) begin
            instrMem[i] = progWords[i];
        end
        interpret();
        resetDut();
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (outputValid) begin
                got.push_back(outputPort);
            end
            if (cycles == CYCLE_LIMIT) begin
                abortRun($sformatf("%s did not halt within %0d cycles", name, CYCLE_LIMIT));
            end
        end while (!isHalted);
        repeat (TAIL_CYCLES) begin   // halted core stays quiet
            @(negedge clk);
            checkValue("isHalted", {15'd0, isHalted}, 16'd1);
            checkValue("outputValid", {15'd0, outputValid}, 16'd0);
            checkValue("instrRead", {15'd0, instrRead}, 16'd0);
        end
        checkValue("output count", 16'(got.size()), 16'(expOut.size()));
        foreach (got[i]) begin
            checkValue($sformatf("outputPort[%0d]", i), got[i], expOut[i]);
        end
        checkValue("numInst", numInst, 16'(expCount));
        for (int i = 0; i < MEM_WORDS; i++) begin
            checkValue($sformatf("dataMem[%0d]", i), dataMem[i], refMem[i]);
        end
        $display("%s: %0d outputs, %0d instructions", name, got.size(), expCount);
    endtask

    task automatic aluChain();
        progWords.delete();
        emit(iType(isaPkg::ADI, R0, R1, 8'd5));
        emit(iType(isaPkg::ADI, R1, R2, 8'd3));
        emit(rType(isaPkg::ADD, R1, R2, R3));
        emit(rType(isaPkg::SUB, R3, R1, R0));
        emit(writeOut(R0));
        emit(rType(isaPkg::NOT, R3, R0, R1));
        emit(rType(isaPkg::TCP, R1, R0, R2));
        emit(rType(isaPkg::SHL, R2, R0, R3));
        emit(rType(isaPkg::SHR, R3, R0, R0));
        emit(writeOut(R1));
        emit(writeOut(R2));
        emit(writeOut(R3));
        emit(writeOut(R0));
        emit(iType(isaPkg::LHI, R0, R1, 8'ha5));
        emit(iType(isaPkg::ORI, R1, R1, 8'h3c));
        emit(rType(isaPkg::AND, R1, R3, R2));
        emit(rType(isaPkg::ORR, R2, R1, R3));
        emit(writeOut(R1));
        emit(writeOut(R2));
        emit(writeOut(R3));
        emit(iType(isaPkg::ADI, R3, R0, 8'h80));
        emit(writeOut(R0));
        emit(rType(isaPkg::HLT, R0, R0, R0));
        runProgram("aluChain");
    endtask

    task automatic storeLoad();
        progWords.delete();
        emit(iType(isaPkg::ADI, R0, R1, 8'h2a));
        emit(iType(isaPkg::ADI, R0, R2, 8'h11));   // base address
        emit(iType(isaPkg::SWD, R2, R1, 8'd3));
        emit(iType(isaPkg::LWD, R2, R3, 8'd3));
        emit(writeOut(R3));                        // load-use stall
        emit(iType(isaPkg::LWD, R2, R0, 8'd5));
        emit(rType(isaPkg::ADD, R0, R3, R1));
        emit(writeOut(R1));
        emit(iType(isaPkg::SWD, R2, R1, 8'hff));
        emit(rType(isaPkg::HLT, R0, R0, R0));
        runProgram("storeLoad");
    endtask

    // marker bump, branch over one word, marker output
    function automatic void branchCase(isaPkg::opcodeT op, isaPkg::regIdxT rs,
                                       isaPkg::regIdxT rt);
        emit(iType(isaPkg::ADI, R3, R3, 8'd1));
        emit(iType(op, rs, rt, 8'd1));
        emit(writeOut(R3));
    endfunction

    task automatic branchesJumps();
        int base;
        progWords.delete();
        emit(iType(isaPkg::ADI, R0, R1, 8'd1));
        emit(iType(isaPkg::ADI, R0, R2, 8'hff));
        emit(iType(isaPkg::BLZ, R2, R0, 8'd1));   // operand still in ID/EX
        emit(writeOut(R2));
        branchCase(isaPkg::BEQ, R1, R2);
        branchCase(isaPkg::BNE, R1, R2);
        branchCase(isaPkg::BGZ, R1, R0);
        branchCase(isaPkg::BGZ, R2, R0);
        branchCase(isaPkg::BLZ, R1, R0);
        branchCase(isaPkg::BLZ, R2, R0);
        branchCase(isaPkg::BEQ, R2, R2);
        branchCase(isaPkg::BNE, R1, R1);
        base = progWords.size();
        emit(jType(isaPkg::JAL, 12'(base + 6)));
        emit(writeOut(R2));                        // return point
        emit(iType(isaPkg::ADI, R0, R3, 8'(base + 9)));
        emit(rType(isaPkg::JPR, R3, R0, R0));
        emit(writeOut(R1));
        emit(writeOut(R1));
        emit(writeOut(R2));                        // subroutine
        emit(rType(isaPkg::JPR, R2, R0, R0));
        emit(writeOut(R1));
        emit(iType(isaPkg::ADI, R0, R0, 8'(base + 13)));
        emit(rType(isaPkg::JRL, R0, R0, R0));
        emit(writeOut(R1));
        emit(writeOut(R1));
        emit(writeOut(R2));
        emit(jType(isaPkg::JMP, 12'(base + 16)));
        emit(writeOut(R1));
        emit(rType(isaPkg::HLT, R0, R0, R0));
        runProgram("branchesJumps");
    endtask

    task automatic randomProgram();
        logic [15:0] kind;
        logic [15:0] regs;
        logic [15:0] imm;
        progWords.delete();
        for (int n = 0; n < RANDOM_LENGTH; n++) begin
            kind = randomBits(4);
            regs = randomBits(6);
            imm = randomBits(8);
            if (!kind[3]) begin
                emit(rType(isaPkg::funcT'({3'b000, kind[2:0]}), regs[5:4], regs[3:2],
                           regs[1:0]));
            end else begin
                case (kind[2:0])
                    3'd0, 3'd1: emit(iType(isaPkg::ADI, regs[5:4], regs[3:2], imm[7:0]));
                    3'd2:       emit(iType(isaPkg::ORI, regs[5:4], regs[3:2], imm[7:0]));
                    3'd3:       emit(iType(isaPkg::LHI, regs[5:4], regs[3:2], imm[7:0]));
                    default:    emit(writeOut(regs[5:4]));
                endcase
            end
        end
        emit(rType(isaPkg::HLT, R0, R0, R0));
        runProgram("randomProgram");
    endtask

    initial begin
        aluChain();
        storeLoad();
        branchesJumps();
        randomProgram();
        $display("No errors");
        $finish;
    end

endmodule

//--- pipelineCpu.f
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/fetchStage.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memWriteback.sv
hdl/pipelineCpu.sv
test/tbPipelineCpu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -f pipelineCpu.f --top-module tbPipelineCpu -o simPipelineCpu
./obj_dir/simPipelineCpu | tee sim.log
if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
